/* verilog/core_mem_pkg.sv */
package core_mem_pkg;

    //////////////////////////////
    // Requester ids

    // Tag carried with each memory request and echoed back as rid
    typedef logic [1:0] mem_id_t;

    localparam mem_id_t ID_DCACHE = 2'd0;
    localparam mem_id_t ID_ICACHE = 2'd1;
    localparam mem_id_t ID_DMMU = 2'd2;
    localparam mem_id_t ID_IMMU = 2'd3;

    //////////////////////////////
    // Requester side

    // Read-only requester (I$, DMMU, IMMU)
    typedef struct packed {
        logic request;
        logic [29:0] addr;
        // Burst length minus one
        logic [4:0] rlen;
    } rd_req_t;

    // Data cache, reads and writes
    typedef struct packed {
        logic request;
        logic [29:0] addr;
        logic [4:0] rlen;
        logic rnw;
        logic [3:0] wbe;
        logic [31:0] wdata;
    } dc_req_t;

    // Per-port response, rdata shared by all ports
    typedef struct packed {
        logic ack;
        logic rvalid;
        logic [31:0] rdata;
    } port_rsp_t;

    //////////////////////////////
    // Memory side

    typedef struct packed {
        logic request;
        logic [29:0] addr;
        logic [4:0] rlen;
        logic rnw;
        logic [3:0] wbe;
        logic [31:0] wdata;
        mem_id_t id;
    } mem_req_t;

    typedef struct packed {
        logic ack;
        logic rvalid;
        mem_id_t rid;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

/* verilog/round_robin.sv */
`timescale 1ns/1ps

module round_robin #(
    parameter int NUM_PORTS = 4
) (
    input logic clk,
    input logic reset,
    input logic [NUM_PORTS-1:0] requests,
    input logic grant,
    output logic [$clog2(NUM_PORTS)-1:0] grantee
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    // Port granted most recently, lowest priority next round
    logic [IDX_W-1:0] last_grant;

    //////////////////////////////
    // Winner selection

    // Walk from furthest to nearest after last_grant
    // so the nearest requesting port is assigned last and wins
    always_comb begin
        int idx;
        idx = 0;
        // Nothing requesting, hold on the last grant
        grantee = last_grant;
        for (int k = NUM_PORTS; k >= 1; k--) begin
            idx = (int'(last_grant) + k) % NUM_PORTS;
            if (requests[idx]) begin
                grantee = IDX_W'(idx);
            end
        end
    end

    //////////////////////////////
    // Pointer update

    // Reset to the top port so port 0 goes first
    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= IDX_W'(NUM_PORTS - 1);
        end else if (grant) begin
            last_grant <= grantee;
        end
    end

endmodule

/* verilog/core_arbiter.sv */
`timescale 1ns/1ps

module core_arbiter #(
    parameter logic INCLUDE_DCACHE = 1'b1,
    parameter logic INCLUDE_ICACHE = 1'b1,
    parameter logic INCLUDE_MMUS = 1'b1
) (
    input logic clk,
    input logic reset,

    input core_mem_pkg::dc_req_t dcache_req,
    input core_mem_pkg::rd_req_t icache_req,
    input core_mem_pkg::rd_req_t dmmu_req,
    input core_mem_pkg::rd_req_t immu_req,

    output core_mem_pkg::port_rsp_t dcache_rsp,
    output core_mem_pkg::port_rsp_t icache_rsp,
    output core_mem_pkg::port_rsp_t dmmu_rsp,
    output core_mem_pkg::port_rsp_t immu_rsp,

    output core_mem_pkg::mem_req_t mem_req,
    input core_mem_pkg::mem_rsp_t mem_rsp
);

    import core_mem_pkg::*;

    // Build-time enables, bit position is the requester id
    localparam logic [3:0] PORT_EN = {INCLUDE_MMUS, INCLUDE_MMUS, INCLUDE_ICACHE, INCLUDE_DCACHE};

    logic [3:0] request;
    logic [3:0][29:0] addr;
    logic [3:0][4:0] rlen;
    logic [3:0] rnw;
    mem_id_t port;
    logic mem_grant;

    // ack follows the selected port, rvalid follows the returned tag
    function automatic port_rsp_t steer_rsp(
        input mem_rsp_t rsp,
        input mem_id_t sel,
        input mem_id_t own
    );
        port_rsp_t r;
        r.ack = rsp.ack && (sel == own);
        r.rvalid = rsp.rvalid && (rsp.rid == own);
        r.rdata = rsp.rdata;
        return r;
    endfunction

    //////////////////////////////
    // Request gathering

    // D$
    assign request[ID_DCACHE] = dcache_req.request & PORT_EN[ID_DCACHE];
    assign addr[ID_DCACHE] = dcache_req.addr;
    assign rlen[ID_DCACHE] = dcache_req.rlen;
    assign rnw[ID_DCACHE] = dcache_req.rnw;

    // I$, read only
    assign request[ID_ICACHE] = icache_req.request & PORT_EN[ID_ICACHE];
    assign addr[ID_ICACHE] = icache_req.addr;
    assign rlen[ID_ICACHE] = icache_req.rlen;
    assign rnw[ID_ICACHE] = 1'b1;

    // DMMU, read only
    assign request[ID_DMMU] = dmmu_req.request & PORT_EN[ID_DMMU];
    assign addr[ID_DMMU] = dmmu_req.addr;
    assign rlen[ID_DMMU] = dmmu_req.rlen;
    assign rnw[ID_DMMU] = 1'b1;

    // IMMU, read only
    assign request[ID_IMMU] = immu_req.request & PORT_EN[ID_IMMU];
    assign addr[ID_IMMU] = immu_req.addr;
    assign rlen[ID_IMMU] = immu_req.rlen;
    assign rnw[ID_IMMU] = 1'b1;

    //////////////////////////////
    // Arbitration

    // Advance only on an accepted transfer
    assign mem_grant = mem_req.request & mem_rsp.ack;

    round_robin #(
        .NUM_PORTS(4)
    ) u_round_robin (
        .clk(clk),
        .reset(reset),
        .requests(request),
        .grant(mem_grant),
        .grantee(port)
    );

    // Selected port onto the memory bus, tagged with its id
    assign mem_req.request = |request;
    assign mem_req.addr = addr[port];
    assign mem_req.rlen = rlen[port];
    assign mem_req.rnw = rnw[port];
    assign mem_req.id = port;
    // Only the D$ writes
    assign mem_req.wbe = dcache_req.wbe;
    assign mem_req.wdata = dcache_req.wdata;

    //////////////////////////////
    // Response routing

    assign dcache_rsp = steer_rsp(mem_rsp, port, ID_DCACHE);
    assign icache_rsp = steer_rsp(mem_rsp, port, ID_ICACHE);
    assign dmmu_rsp = steer_rsp(mem_rsp, port, ID_DMMU);
    assign immu_rsp = steer_rsp(mem_rsp, port, ID_IMMU);

endmodule

/* verilog/burst_memory.sv */
`timescale 1ns/1ps

module burst_memory #(
    parameter int DEPTH_WORDS = 1024
) (
    input logic clk,
    input logic reset,
    input core_mem_pkg::mem_req_t mem_req,
    output core_mem_pkg::mem_rsp_t mem_rsp
);

    import core_mem_pkg::*;

    localparam int ADDR_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    logic [31:0] mem [DEPTH_WORDS];

    // Burst engine state
    logic burst_active;
    logic [4:0] remaining;
    logic [ADDR_W-1:0] next_addr;
    mem_id_t rid_q;
    logic [31:0] rdata_q;

    logic accept;
    logic [29:0] start_mod;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] start_inc;
    logic [ADDR_W-1:0] next_inc;

    // Next word index with wrap at the depth
    function automatic logic [ADDR_W-1:0] wrap_inc(input logic [ADDR_W-1:0] a);
        if (int'(a) == DEPTH_WORDS - 1) begin
            return '0;
        end
        return a + 1'b1;
    endfunction

    //////////////////////////////
    // Acceptance

    // Idle means no burst words still to return
    assign accept = mem_req.request & ~burst_active;

    // Request address taken modulo the depth
    assign start_mod = mem_req.addr % 30'(DEPTH_WORDS);
    assign start_addr = start_mod[ADDR_W-1:0];
    assign start_inc = wrap_inc(start_addr);
    assign next_inc = wrap_inc(next_addr);

    //////////////////////////////
    // Control

    // One cycle after a read acceptance the first word is out,
    // then one word per cycle until remaining hits zero
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_active <= 1'b0;
        end else if (accept && mem_req.rnw) begin
            burst_active <= 1'b1;
        end else if (burst_active && remaining == 5'd0) begin
            burst_active <= 1'b0;
        end
    end

    //////////////////////////////
    // Storage and datapath

    always_ff @(posedge clk) begin
        if (accept && mem_req.rnw) begin
            // Load first word and latch burst parameters
            rdata_q <= mem[start_addr];
            next_addr <= start_inc;
            remaining <= mem_req.rlen;
            rid_q <= mem_req.id;
        end else if (burst_active && remaining != 5'd0) begin
            rdata_q <= mem[next_addr];
            next_addr <= next_inc;
            remaining <= remaining - 5'd1;
        end

        // Single word write, enabled bytes only
        if (accept && !mem_req.rnw) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.wbe[b]) begin
                    mem[start_addr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Response

    // ack is combinational, low for the whole burst
    assign mem_rsp.ack = accept;
    assign mem_rsp.rvalid = burst_active;
    assign mem_rsp.rid = rid_q;
    assign mem_rsp.rdata = rdata_q;

endmodule

/* verilog/core_mem_top.sv */
`timescale 1ns/1ps

module core_mem_top #(
    parameter logic INCLUDE_DCACHE = 1'b1,
    parameter logic INCLUDE_ICACHE = 1'b1,
    parameter logic INCLUDE_MMUS = 1'b1,
    parameter int DEPTH_WORDS = 1024
) (
    input logic clk,
    input logic reset,

    input core_mem_pkg::dc_req_t dcache_req,
    input core_mem_pkg::rd_req_t icache_req,
    input core_mem_pkg::rd_req_t dmmu_req,
    input core_mem_pkg::rd_req_t immu_req,

    output core_mem_pkg::port_rsp_t dcache_rsp,
    output core_mem_pkg::port_rsp_t icache_rsp,
    output core_mem_pkg::port_rsp_t dmmu_rsp,
    output core_mem_pkg::port_rsp_t immu_rsp
);

    import core_mem_pkg::*;

    // Shared memory port between arbiter and memory model
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    //////////////////////////////
    // Arbiter

    core_arbiter #(
        .INCLUDE_DCACHE(INCLUDE_DCACHE),
        .INCLUDE_ICACHE(INCLUDE_ICACHE),
        .INCLUDE_MMUS(INCLUDE_MMUS)
    ) u_core_arbiter (
        .clk(clk),
        .reset(reset),
        .dcache_req(dcache_req),
        .icache_req(icache_req),
        .dmmu_req(dmmu_req),
        .immu_req(immu_req),
        .dcache_rsp(dcache_rsp),
        .icache_rsp(icache_rsp),
        .dmmu_rsp(dmmu_rsp),
        .immu_rsp(immu_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    //////////////////////////////
    // Memory model

    burst_memory #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) u_burst_memory (
        .clk(clk),
        .reset(reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

/* dv/core_mem_checker.sv */
`timescale 1ns/1ps

module core_arbiter_checker (
    input logic clk,
    input logic reset,
    input logic [3:0] request,
    input core_mem_pkg::mem_id_t port,
    input core_mem_pkg::mem_rsp_t mem_rsp,
    input core_mem_pkg::port_rsp_t dcache_rsp,
    input core_mem_pkg::port_rsp_t icache_rsp,
    input core_mem_pkg::port_rsp_t dmmu_rsp,
    input core_mem_pkg::port_rsp_t immu_rsp
);

    import core_mem_pkg::*;

    logic [3:0] acks;
    logic [3:0] rvalids;
    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Bit position is the requester id
    assign acks = {immu_rsp.ack, dmmu_rsp.ack, icache_rsp.ack, dcache_rsp.ack};
    assign rvalids = {immu_rsp.rvalid, dmmu_rsp.rvalid, icache_rsp.rvalid, dcache_rsp.rvalid};

    //////////////////////////////
    // Routing properties

    a_single_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(acks))
        else begin
            $error("more than one requester port sees ack");
            fail_count++;
        end

    a_single_rvalid: assert property (@(posedge clk) disable iff (reset) $onehot0(rvalids))
        else begin
            $error("more than one requester port sees rvalid");
            fail_count++;
        end

    // Memory only accepts on behalf of a live request
    a_ack_requesting: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.ack |-> request[port])
        else begin
            $error("memory ack while the selected port is not requesting");
            fail_count++;
        end

    a_rvalid_by_rid: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.rvalid |-> (rvalids == (4'b0001 << mem_rsp.rid)))
        else begin
            $error("rvalid did not reach the port named by rid");
            fail_count++;
        end

endmodule

bind core_arbiter core_arbiter_checker u_checker (
    .clk(clk),
    .reset(reset),
    .request(request),
    .port(port),
    .mem_rsp(mem_rsp),
    .dcache_rsp(dcache_rsp),
    .icache_rsp(icache_rsp),
    .dmmu_rsp(dmmu_rsp),
    .immu_rsp(immu_rsp)
);

/* dv/core_mem_tb.sv */
`timescale 1ns/1ps

module core_mem_tb;

    import core_mem_pkg::*;

    localparam int DEPTH = 1024;
    // Tests need a few hundred cycles at most
    localparam int MAX_CYCLES = 3000;

    logic clk;
    logic reset;
    dc_req_t dcache_req;
    // Index 0 unused, the data cache has its own struct
    rd_req_t ro_req [4];
    port_rsp_t dcache_rsp;
    port_rsp_t icache_rsp;
    port_rsp_t dmmu_rsp;
    port_rsp_t immu_rsp;
    port_rsp_t rsp [4];

    // Expected memory contents
    logic [31:0] shadow [DEPTH];
    logic [31:0] rng;
    logic [29:0] base_addr;
    string test_name;
    int errors;

    // Monitor state
    logic [31:0] rx_buf [4][256];
    int rx_cnt [4];
    int acc_cycle [4];
    int acc_count [4];
    int first_rv [4];
    mem_id_t ack_log [$];
    int rd_port;
    int rd_left;
    int rd_len;
    int mon_errors;
    int cycle;

    core_mem_top #(
        .INCLUDE_DCACHE(1'b1),
        .INCLUDE_ICACHE(1'b1),
        .INCLUDE_MMUS(1'b1),
        .DEPTH_WORDS(DEPTH)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .dcache_req(dcache_req),
        .icache_req(ro_req[ID_ICACHE]),
        .dmmu_req(ro_req[ID_DMMU]),
        .immu_req(ro_req[ID_IMMU]),
        .dcache_rsp(dcache_rsp),
        .icache_rsp(icache_rsp),
        .dmmu_rsp(dmmu_rsp),
        .immu_rsp(immu_rsp)
    );

    // Responses indexed by requester id
    assign rsp[ID_DCACHE] = dcache_rsp;
    assign rsp[ID_ICACHE] = icache_rsp;
    assign rsp[ID_DMMU] = dmmu_rsp;
    assign rsp[ID_IMMU] = immu_rsp;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a request or burst never completed", cycle);
            $display("Errors: %0d",
                     errors + mon_errors + 1 + u_dut.u_core_arbiter.u_checker.fail_count);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////
    // Port monitor

    // Sampled mid-cycle, one burst in flight at a time
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < 4; p++) begin
                if (rsp[p].rvalid) begin
                    if (p != rd_port || rd_left == 0) begin
                        $display("Test %s: rvalid on port %0d with no read in flight for it",
                                 test_name, p);
                        mon_errors++;
                    end else begin
                        if (rd_left == rd_len) begin
                            first_rv[p] = cycle;
                        end
                        rx_buf[p][rx_cnt[p] % 256] = rsp[p].rdata;
                        rx_cnt[p]++;
                        rd_left--;
                    end
                end
            end
            for (int p = 0; p < 4; p++) begin
                if (rsp[p].ack) begin
                    if (rd_left != 0) begin
                        $display("Test %s: port %0d acked while a burst was still running",
                                 test_name, p);
                        mon_errors++;
                    end
                    ack_log.push_back(mem_id_t'(p));
                    acc_cycle[p] = cycle;
                    acc_count[p]++;
                    // Writes start no burst
                    if (p != 0 || dcache_req.rnw) begin
                        rd_port = p;
                        rd_len = (p == 0) ? int'(dcache_req.rlen) + 1 : int'(ro_req[p].rlen) + 1;
                        rd_left = rd_len;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Helpers and checks

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int word_index(input logic [29:0] a);
        return int'(a % 30'(DEPTH));
    endfunction

    task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %08h actual %08h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string what, input mem_id_t exp, input mem_id_t act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic drive_port(input mem_id_t p, input logic on, input logic [29:0] addr,
                              input logic [4:0] rlen);
        if (p == ID_DCACHE) begin
            dcache_req.request = on;
            dcache_req.addr = addr;
            dcache_req.rlen = rlen;
            dcache_req.rnw = 1'b1;
            dcache_req.wbe = 4'h0;
        end else begin
            ro_req[p].request = on;
            ro_req[p].addr = addr;
            ro_req[p].rlen = rlen;
        end
    endtask

    // Returns one ns into the cycle after acceptance
    task automatic wait_ack(input mem_id_t p);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = rsp[p].ack;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_word(input logic [29:0] addr, input logic [3:0] wbe,
                              input logic [31:0] data);
        int idx;
        idx = word_index(addr);
        dcache_req = '{request: 1'b1, addr: addr, rlen: 5'd0, rnw: 1'b0, wbe: wbe, wdata: data};
        wait_ack(ID_DCACHE);
        dcache_req.request = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (wbe[b]) begin
                shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic read_burst(input mem_id_t p, input logic [29:0] addr, input logic [4:0] rlen);
        int start;
        int n;
        start = rx_cnt[p];
        n = int'(rlen) + 1;
        drive_port(p, 1'b1, addr, rlen);
        wait_ack(p);
        drive_port(p, 1'b0, addr, rlen);
        while (rx_cnt[p] < start + n) begin
            @(posedge clk);
            #1;
        end
        check_count("first rvalid cycle", acc_cycle[p] + 1, first_rv[p]);
        for (int k = 0; k < n; k++) begin
            check_data("read word", shadow[word_index(addr + 30'(k))],
                       rx_buf[p][(start + k) % 256]);
        end
    endtask

    //////////////////////////////
    // Tests

    task automatic test_write_readback();
        logic [31:0] r;
        test_name = "write_readback";
        r = next_rand();
        base_addr = r[29:0];
        for (int k = 0; k < 8; k++) begin
            write_word(base_addr + 30'(k), 4'hf, next_rand());
        end
        read_burst(ID_DCACHE, base_addr, 5'd7);
    endtask

    task automatic test_byte_enables();
        test_name = "byte_enables";
        write_word(base_addr + 30'd1, 4'b0101, next_rand());
        write_word(base_addr + 30'd2, 4'b1000, next_rand());
        read_burst(ID_DCACHE, base_addr + 30'd1, 5'd1);
    endtask

    task automatic test_read_only_ports();
        test_name = "read_only_ports";
        read_burst(ID_ICACHE, base_addr, 5'd7);
        read_burst(ID_DMMU, base_addr + 30'd2, 5'd3);
        read_burst(ID_IMMU, base_addr + 30'd5, 5'd0);
    endtask

    task automatic test_fairness(input mem_id_t lead);
        mem_id_t exp_order [4];
        int first;
        test_name = "fairness";
        // Lone request, so lead becomes the last granted port
        read_burst(lead, base_addr + 30'd4, 5'd0);
        first = ack_log.size();
        for (int i = 0; i < 4; i++) begin
            exp_order[i] = mem_id_t'(int'(lead) + 1 + i);
        end
        fork
            read_burst(ID_DCACHE, base_addr, 5'd0);
            read_burst(ID_ICACHE, base_addr + 30'd1, 5'd0);
            read_burst(ID_DMMU, base_addr + 30'd2, 5'd0);
            read_burst(ID_IMMU, base_addr + 30'd3, 5'd0);
        join
        check_count("grant count", 4, ack_log.size() - first);
        for (int i = 0; i < 4; i++) begin
            check_id("grant order", exp_order[i], ack_log[first + i]);
        end
    endtask

    task automatic test_back_pressure();
        int start;
        test_name = "back_pressure";
        start = acc_count[ID_DCACHE];
        fork
            read_burst(ID_DCACHE, base_addr, 5'd7);
            begin
                // Raise the I$ request once the D$ burst is running
                while (acc_count[ID_DCACHE] == start) begin
                    @(posedge clk);
                    #1;
                end
                read_burst(ID_ICACHE, base_addr + 30'd3, 5'd1);
            end
        join
        // Eight words, then the memory is idle again
        check_count("second accept cycle", acc_cycle[ID_DCACHE] + 7 + 2, acc_cycle[ID_ICACHE]);
    endtask

    initial begin
        reset = 1'b1;
        dcache_req = '0;
        for (int p = 0; p < 4; p++) begin
            ro_req[p] = '0;
        end
        rng = 32'd28;
        errors = 0;
        base_addr = '0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_write_readback();
        test_byte_enables();
        test_read_only_ports();
        test_fairness(ID_ICACHE);
        test_fairness(ID_DMMU);
        test_back_pressure();

        repeat (2) @(posedge clk);
        errors = errors + mon_errors + u_dut.u_core_arbiter.u_checker.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* core_mem.f */
verilog/core_mem_pkg.sv
verilog/round_robin.sv
verilog/core_arbiter.sv
verilog/burst_memory.sv
verilog/core_mem_top.sv
dv/core_mem_checker.sv
dv/core_mem_tb.sv

/* Makefile */
# Verilator build and run for core_mem

VERILATOR ?= verilator
TOP ?= core_mem_tb
FILELIST ?= core_mem.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
